// File: all.f
rv_isa_pkg.sv
exec_pkg.sv
decode_unit.sv
reg_file.sv
alu_unit.sv
muldiv_unit.sv
writeback_unit.sv
exec_core.sv
exec_core_sva.sv
tb_exec_core.sv

// File: alu_unit.sv
module alu_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            alu_start,
    input  exec_pkg::uop_e  uop,
    input  exec_pkg::word_t op_a,
    input  exec_pkg::word_t op_b,
    output logic            alu_done,
    output exec_pkg::word_t alu_result
);

    exec_pkg::word_t res;
    logic [4:0]      shamt;

    assign shamt = op_b[4:0];

    always_comb begin
        case (uop)
            exec_pkg::ADD:    res = op_a + op_b;
            exec_pkg::SUB:    res = op_a - op_b;
            exec_pkg::SLL:    res = op_a << shamt;
            exec_pkg::SLT:    res = exec_pkg::word_t'($signed(op_a) < $signed(op_b));
            exec_pkg::SLTU:   res = exec_pkg::word_t'(op_a < op_b);
            exec_pkg::XOR:    res = op_a ^ op_b;
            exec_pkg::SRL:    res = op_a >> shamt;
            exec_pkg::SRA:    res = $signed(op_a) >>> shamt;
            exec_pkg::OR:     res = op_a | op_b;
            exec_pkg::AND:    res = op_a & op_b;
            exec_pkg::PASS_B: res = op_b;
            default:          res = '0;  // m-ext ops never reach here
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            alu_done <= 1'b0;
        else
            alu_done <= alu_start;
    end

    always_ff @(posedge clk) begin
        if (alu_start)
            alu_result <= res;
    end

endmodule

// File: decode_unit.sv
module decode_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid,
    input  exec_pkg::word_t    instr,
    input  logic               retire_valid,
    output logic               instr_ready,
    output exec_pkg::reg_idx_t rs1_addr,
    output exec_pkg::reg_idx_t rs2_addr,
    input  exec_pkg::word_t    rs1_data,
    input  exec_pkg::word_t    rs2_data,
    output logic               alu_start,
    output logic               muldiv_start,
    output exec_pkg::uop_e     uop,
    output exec_pkg::word_t    op_a,
    output exec_pkg::word_t    op_b,
    output exec_pkg::reg_idx_t rd,
    output logic               illegal,
    output logic               illegal_valid
);

    exec_pkg::word_t     instr_q;
    logic                busy;
    logic                pend;   // accepted, not yet issued
    rv_isa_pkg::opcode_e opc;
    logic [2:0]          f3;
    logic [6:0]          f7;
    exec_pkg::uop_e      uop_d;
    exec_pkg::word_t     op_b_d;
    logic                legal;
    logic                is_md;

    function automatic exec_pkg::uop_e base_uop(input logic [2:0] fn3, input logic alt);
        exec_pkg::uop_e u;
        u = exec_pkg::ADD;
        case (fn3)
            rv_isa_pkg::F3_ADD_SUB: u = alt ? exec_pkg::SUB : exec_pkg::ADD;
            rv_isa_pkg::F3_SLL:     u = exec_pkg::SLL;
            rv_isa_pkg::F3_SLT:     u = exec_pkg::SLT;
            rv_isa_pkg::F3_SLTU:    u = exec_pkg::SLTU;
            rv_isa_pkg::F3_XOR:     u = exec_pkg::XOR;
            rv_isa_pkg::F3_SRL_SRA: u = alt ? exec_pkg::SRA : exec_pkg::SRL;
            rv_isa_pkg::F3_OR:      u = exec_pkg::OR;
            rv_isa_pkg::F3_AND:     u = exec_pkg::AND;
        endcase
        return u;
    endfunction

    assign instr_ready = ~busy;
    assign opc      = rv_isa_pkg::opcode_e'(instr_q[6:0]);
    assign f3       = instr_q[rv_isa_pkg::F3_LSB +: 3];
    assign f7       = instr_q[rv_isa_pkg::F7_LSB +: 7];
    assign rs1_addr = instr_q[rv_isa_pkg::RS1_LSB +: 5];
    assign rs2_addr = instr_q[rv_isa_pkg::RS2_LSB +: 5];

    always_comb begin
        uop_d  = exec_pkg::ADD;
        op_b_d = rs2_data;
        legal  = 1'b1;
        is_md  = 1'b0;
        case (opc)
            rv_isa_pkg::OP: begin
                if (f7 == rv_isa_pkg::F7_MULDIV) begin
                    is_md = 1'b1;
                    case (f3)
                        rv_isa_pkg::F3_MUL:    uop_d = exec_pkg::MUL;
                        rv_isa_pkg::F3_MULH:   uop_d = exec_pkg::MULH;
                        rv_isa_pkg::F3_MULHSU: uop_d = exec_pkg::MULHSU;
                        rv_isa_pkg::F3_MULHU:  uop_d = exec_pkg::MULHU;
                        rv_isa_pkg::F3_DIV:    uop_d = exec_pkg::DIV;
                        rv_isa_pkg::F3_DIVU:   uop_d = exec_pkg::DIVU;
                        rv_isa_pkg::F3_REM:    uop_d = exec_pkg::REM;
                        rv_isa_pkg::F3_REMU:   uop_d = exec_pkg::REMU;
                    endcase
                end else if (f7 == rv_isa_pkg::F7_BASE) begin
                    uop_d = base_uop(f3, 1'b0);
                end else if (f7 == rv_isa_pkg::F7_ALT &&
                             (f3 == rv_isa_pkg::F3_ADD_SUB || f3 == rv_isa_pkg::F3_SRL_SRA)) begin
                    uop_d = base_uop(f3, 1'b1);
                end else begin
                    legal = 1'b0;
                end
            end
            rv_isa_pkg::OP_IMM: begin
                op_b_d = {{(exec_pkg::XLEN-12){instr_q[31]}}, instr_q[31:20]};
                uop_d  = base_uop(f3, f3 == rv_isa_pkg::F3_SRL_SRA && f7 == rv_isa_pkg::F7_ALT);
                // shift immediates only allow the two funct7 forms
                if (f3 == rv_isa_pkg::F3_SLL && f7 != rv_isa_pkg::F7_BASE)
                    legal = 1'b0;
                if (f3 == rv_isa_pkg::F3_SRL_SRA && f7 != rv_isa_pkg::F7_BASE &&
                    f7 != rv_isa_pkg::F7_ALT)
                    legal = 1'b0;
            end
            rv_isa_pkg::LUI: begin
                uop_d  = exec_pkg::PASS_B;
                op_b_d = {instr_q[31:12], 12'b0};
            end
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            pend          <= 1'b0;
            alu_start     <= 1'b0;
            muldiv_start  <= 1'b0;
            illegal_valid <= 1'b0;
        end else begin
            if (instr_valid && instr_ready)
                busy <= 1'b1;
            else if (retire_valid)
                busy <= 1'b0;
            pend          <= instr_valid && instr_ready;
            alu_start     <= pend && legal && !is_md;
            muldiv_start  <= pend && legal && is_md;
            illegal_valid <= pend && !legal;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid && instr_ready)
            instr_q <= instr;
        if (pend) begin
            uop     <= uop_d;
            op_a    <= rs1_data;
            op_b    <= op_b_d;
            rd      <= instr_q[rv_isa_pkg::RD_LSB +: 5];
            illegal <= !legal;
        end
    end

endmodule

// File: exec_core.sv
module exec_core (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid,
    input  exec_pkg::word_t    instr,
    output logic               instr_ready,
    output logic               retire_valid,
    output exec_pkg::reg_idx_t retire_rd,
    output exec_pkg::word_t    retire_value,
    output logic               retire_illegal
);

    exec_pkg::reg_idx_t rs1_addr;
    exec_pkg::reg_idx_t rs2_addr;
    exec_pkg::word_t    rs1_data;
    exec_pkg::word_t    rs2_data;
    logic               alu_start;
    logic               muldiv_start;
    exec_pkg::uop_e     uop;
    exec_pkg::word_t    op_a;
    exec_pkg::word_t    op_b;
    exec_pkg::reg_idx_t rd;
    logic               illegal;
    logic               illegal_valid;
    logic               alu_done;
    exec_pkg::word_t    alu_result;
    logic               muldiv_done;
    exec_pkg::word_t    muldiv_result;
    logic               wr_en;
    exec_pkg::reg_idx_t wr_addr;
    exec_pkg::word_t    wr_data;

    decode_unit decode_i (
        .clk(clk), .rst_n(rst_n),
        .instr_valid(instr_valid), .instr(instr), .retire_valid(retire_valid),
        .instr_ready(instr_ready),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alu_start(alu_start), .muldiv_start(muldiv_start),
        .uop(uop), .op_a(op_a), .op_b(op_b),
        .rd(rd), .illegal(illegal), .illegal_valid(illegal_valid)
    );

    reg_file regs_i (
        .clk(clk), .rst_n(rst_n),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    alu_unit alu_i (
        .clk(clk), .rst_n(rst_n), .alu_start(alu_start),
        .uop(uop), .op_a(op_a), .op_b(op_b),
        .alu_done(alu_done), .alu_result(alu_result)
    );

    muldiv_unit muldiv_i (
        .clk(clk), .rst_n(rst_n), .muldiv_start(muldiv_start),
        .uop(uop), .op_a(op_a), .op_b(op_b),
        .muldiv_done(muldiv_done), .muldiv_result(muldiv_result)
    );

    writeback_unit wb_i (
        .clk(clk), .rst_n(rst_n),
        .rd(rd), .illegal(illegal), .illegal_valid(illegal_valid),
        .alu_done(alu_done), .alu_result(alu_result),
        .muldiv_done(muldiv_done), .muldiv_result(muldiv_result),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .retire_valid(retire_valid), .retire_rd(retire_rd),
        .retire_value(retire_value), .retire_illegal(retire_illegal)
    );

endmodule

// File: exec_core_sva.sv
module exec_core_sva (
    input logic clk,
    input logic rst_n,
    input logic instr_valid,
    input logic instr_ready,
    input logic retire_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    logic        in_flight;  // accepted and not yet retired
    int unsigned fail_count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            in_flight <= 1'b0;
        else if (instr_valid && instr_ready)
            in_flight <= 1'b1;
        else if (retire_valid)
            in_flight <= 1'b0;
    end

    single_retire: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |=> !retire_valid)
        else begin
            fail_count++;
            $error("retire_valid high on two consecutive cycles");
        end

    ready_drops_on_accept: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid && instr_ready |=> !instr_ready)
        else begin
            fail_count++;
            $error("instr_ready still high after an acceptance");
        end

    ready_rises_after_retire: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(instr_ready) |-> $past(retire_valid))
        else begin
            fail_count++;
            $error("instr_ready rose without a retire in the previous cycle");
        end

    retire_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> in_flight)
        else begin
            fail_count++;
            $error("retire_valid without an accepted instruction");
        end

endmodule

bind exec_core exec_core_sva sva_i (
    .clk(clk),
    .rst_n(rst_n),
    .instr_valid(instr_valid),
    .instr_ready(instr_ready),
    .retire_valid(retire_valid)
);

// File: exec_pkg.sv
package exec_pkg;

    localparam int XLEN       = 32;
    localparam int DIV_STEPS  = 32;  // one quotient bit per step
    localparam int MUL_STAGES = 2;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    typedef enum logic [4:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B,  // lui
        MUL,
        MULH,
        MULHSU,
        MULHU,
        DIV,
        DIVU,
        REM,
        REMU
    } uop_e;

endpackage

// File: muldiv_unit.sv
module muldiv_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            muldiv_start,
    input  exec_pkg::uop_e  uop,
    input  exec_pkg::word_t op_a,
    input  exec_pkg::word_t op_b,
    output logic            muldiv_done,
    output exec_pkg::word_t muldiv_result
);

    localparam int XL    = exec_pkg::XLEN;
    localparam int NS    = exec_pkg::MUL_STAGES;
    localparam int CNT_W = $clog2(exec_pkg::DIV_STEPS + 1);

    typedef enum logic [1:0] {IDLE, RUN, FIX} div_state_e;

    // multiplier
    logic                 is_mul;
    logic                 a_sgn;
    logic                 b_sgn;
    logic signed [XL:0]   a_ext;
    logic signed [XL:0]   b_ext;
    logic [2*XL+1:0]      prod_q [NS];
    logic [NS-1:0]        mv_q;
    logic [NS-1:0]        mhi_q;  // take upper word

    // divider
    div_state_e           state;
    logic [CNT_W-1:0]     cnt;
    logic [XL-1:0]        quo;
    logic [XL-1:0]        rem;
    logic [XL-1:0]        dvsr;
    logic [XL:0]          diff;
    logic                 neg_q;
    logic                 neg_r;
    logic                 by_zero;
    logic                 want_rem;
    logic                 div_sgn;
    logic                 div_done_q;
    exec_pkg::word_t      div_res_q;

    assign is_mul = uop inside {exec_pkg::MUL, exec_pkg::MULH, exec_pkg::MULHSU, exec_pkg::MULHU};
    assign a_sgn  = uop == exec_pkg::MULH || uop == exec_pkg::MULHSU;
    assign b_sgn  = uop == exec_pkg::MULH;
    assign a_ext  = {a_sgn & op_a[XL-1], op_a};
    assign b_ext  = {b_sgn & op_b[XL-1], op_b};

    assign div_sgn = uop == exec_pkg::DIV || uop == exec_pkg::REM;
    assign diff    = {rem, quo[XL-1]} - {1'b0, dvsr};  // trial subtract

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mv_q       <= '0;
            state      <= IDLE;
            div_done_q <= 1'b0;
        end else begin
            mv_q       <= {mv_q[NS-2:0], muldiv_start && is_mul};
            div_done_q <= state == FIX;
            case (state)
                IDLE: if (muldiv_start && !is_mul) state <= RUN;
                RUN:  if (cnt == CNT_W'(exec_pkg::DIV_STEPS - 1)) state <= FIX;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        prod_q[0] <= $signed(a_ext) * $signed(b_ext);
        mhi_q[0]  <= uop != exec_pkg::MUL;
        for (int i = 1; i < NS; i++) begin
            prod_q[i] <= prod_q[i-1];
            mhi_q[i]  <= mhi_q[i-1];
        end

        if (state == IDLE && muldiv_start && !is_mul) begin
            quo      <= (div_sgn && op_a[XL-1]) ? -op_a : op_a;  // magnitudes
            dvsr     <= (div_sgn && op_b[XL-1]) ? -op_b : op_b;
            rem      <= '0;
            cnt      <= '0;
            neg_q    <= div_sgn && (op_a[XL-1] ^ op_b[XL-1]);
            neg_r    <= div_sgn && op_a[XL-1];
            by_zero  <= op_b == '0;
            want_rem <= uop == exec_pkg::REM || uop == exec_pkg::REMU;
        end else if (state == RUN) begin
            cnt <= cnt + 1'b1;
            if (!diff[XL]) begin
                rem <= diff[XL-1:0];
                quo <= {quo[XL-2:0], 1'b1};
            end else begin
                rem <= {rem[XL-2:0], quo[XL-1]};
                quo <= {quo[XL-2:0], 1'b0};
            end
        end

        // rem by zero already equals the dividend after sign fix
        // min / -1 wraps back to the dividend on negation
        if (state == FIX) begin
            if (want_rem)
                div_res_q <= neg_r ? -rem : rem;
            else if (by_zero)
                div_res_q <= '1;
            else
                div_res_q <= neg_q ? -quo : quo;
        end
    end

    assign muldiv_done   = mv_q[NS-1] | div_done_q;
    assign muldiv_result = div_done_q   ? div_res_q :
                           mhi_q[NS-1]  ? prod_q[NS-1][2*XL-1:XL] : prod_q[NS-1][XL-1:0];

endmodule

// File: reg_file.sv
module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  exec_pkg::reg_idx_t rs1_addr,
    input  exec_pkg::reg_idx_t rs2_addr,
    output exec_pkg::word_t    rs1_data,
    output exec_pkg::word_t    rs2_data,
    input  logic               wr_en,
    input  exec_pkg::reg_idx_t wr_addr,
    input  exec_pkg::word_t    wr_data
);

    exec_pkg::word_t regs [32];

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en && wr_addr != '0) begin  // x0 stays zero
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the exec_core testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_exec_core -f all.f \
    && ./obj_dir/Vtb_exec_core | tee /dev/stderr | grep -q "No errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes kept by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcode_e;

    // base integer funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // M extension funct3
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;
    localparam logic [2:0] F3_DIV    = 3'b100;
    localparam logic [2:0] F3_DIVU   = 3'b101;
    localparam logic [2:0] F3_REM    = 3'b110;
    localparam logic [2:0] F3_REMU   = 3'b111;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // sub, sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // field positions (lsb)
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int F7_LSB  = 25;

endpackage

// File: tb_exec_core.sv
module tb_exec_core;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        exec_pkg::word_t    instr;
        exec_pkg::reg_idx_t rd;
        exec_pkg::word_t    value;
        bit                 ill;
        bit                 lat3;  // fixed 3 cycle latency expected
    } row_t;

    logic               clk;
    logic               rst_n;
    logic               instr_valid;
    exec_pkg::word_t    instr;
    logic               instr_ready;
    logic               retire_valid;
    exec_pkg::reg_idx_t retire_rd;
    exec_pkg::word_t    retire_value;
    logic               retire_illegal;

    row_t            rows [$];
    exec_pkg::word_t ref_regs [32];  // architectural state as it should be

    exec_core dut_i (
        .clk(clk), .rst_n(rst_n),
        .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
        .retire_valid(retire_valid), .retire_rd(retire_rd),
        .retire_value(retire_value), .retire_illegal(retire_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic exec_pkg::word_t rr_op(logic [2:0] f3, bit alt, int rd, int rs1, int rs2);
        logic [6:0] f7;
        f7 = alt ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE;
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_isa_pkg::OP};
    endfunction

    function automatic exec_pkg::word_t md_op(logic [2:0] f3, int rd, int rs1, int rs2);
        return {rv_isa_pkg::F7_MULDIV, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_isa_pkg::OP};
    endfunction

    function automatic exec_pkg::word_t imm_op(logic [2:0] f3, int rd, int rs1, logic [11:0] imm);
        return {imm, 5'(rs1), f3, 5'(rd), rv_isa_pkg::OP_IMM};
    endfunction

    function automatic exec_pkg::word_t lui_op(int rd, logic [19:0] imm);
        return {imm, 5'(rd), rv_isa_pkg::LUI};
    endfunction

    function automatic void add_row(exec_pkg::word_t iw, int rd, exec_pkg::word_t value,
                                    bit ill, bit lat3);
        row_t r;
        r.instr = iw;
        r.rd    = 5'(rd);
        r.value = value;
        r.ill   = ill;
        r.lat3  = lat3;
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        // known values
        add_row(lui_op(1, 20'h80000), 1, 32'h80000000, 0, 1);
        add_row(imm_op(rv_isa_pkg::F3_ADD_SUB, 2, 0, 12'hfff), 2, 32'hffffffff, 0, 1);
        add_row(imm_op(rv_isa_pkg::F3_ADD_SUB, 3, 0, 12'h007), 3, 32'h00000007, 0, 1);
        add_row(lui_op(4, 20'h12345), 4, 32'h12345000, 0, 1);
        add_row(imm_op(rv_isa_pkg::F3_OR, 4, 4, 12'h678), 4, 32'h12345678, 0, 1);
        add_row(imm_op(rv_isa_pkg::F3_XOR, 5, 4, 12'hfff), 5, 32'hedcba987, 0, 1);
        add_row(imm_op(rv_isa_pkg::F3_ADD_SUB, 6, 0, 12'hff9), 6, 32'hfffffff9, 0, 1);
        // register-register alu
        add_row(rr_op(rv_isa_pkg::F3_ADD_SUB, 0, 8, 4, 3), 8, 32'h1234567f, 0, 1);
        add_row(rr_op(rv_isa_pkg::F3_ADD_SUB, 1, 9, 3, 4), 9, 32'hedcba98f, 0, 1);
        add_row(rr_op(rv_isa_pkg::F3_SLL, 0, 10, 4, 3), 10, 32'h1a2b3c00, 0, 1);
        add_row(rr_op(rv_isa_pkg::F3_SLT, 0, 11, 6, 3), 11, 32'h00000001, 0, 1);
        add_row(rr_op(rv_isa_pkg::F3_SLTU, 0, 12, 6, 3), 12, 32'h00000000, 0, 1);
        add_row(rr_op(rv_isa_pkg::F3_XOR, 0, 13, 4, 2), 13, 32'hedcba987, 0, 1);
        add_row(rr_op(rv_isa_pkg::F3_SRL_SRA, 0, 14, 1, 3), 14, 32'h01000000, 0, 1);
        add_row(rr_op(rv_isa_pkg::F3_SRL_SRA, 1, 15, 1, 3), 15, 32'hff000000, 0, 1);
        add_row(rr_op(rv_isa_pkg::F3_OR, 0, 16, 3, 6), 16, 32'hffffffff, 0, 1);
        add_row(rr_op(rv_isa_pkg::F3_AND, 0, 17, 5, 6), 17, 32'hedcba981, 0, 1);
        // immediate alu
        add_row(imm_op(rv_isa_pkg::F3_SLT, 18, 6, 12'hffa), 18, 32'h00000001, 0, 1);
        add_row(imm_op(rv_isa_pkg::F3_SLTU, 19, 3, 12'hfff), 19, 32'h00000001, 0, 1);
        add_row(imm_op(rv_isa_pkg::F3_AND, 20, 4, 12'h0f0), 20, 32'h00000070, 0, 1);
        add_row(imm_op(rv_isa_pkg::F3_SLL, 21, 3, 12'h01c), 21, 32'h70000000, 0, 1);
        add_row(imm_op(rv_isa_pkg::F3_SRL_SRA, 22, 2, 12'h004), 22, 32'h0fffffff, 0, 1);
        add_row(imm_op(rv_isa_pkg::F3_SRL_SRA, 23, 1, 12'h404), 23, 32'hf8000000, 0, 1);
        add_row(imm_op(rv_isa_pkg::F3_SLT, 24, 3, 12'h007), 24, 32'h00000000, 0, 1);
        // multiply -7 against positive and all-ones operands
        add_row(md_op(rv_isa_pkg::F3_MUL, 25, 6, 4), 25, 32'h8091a2b8, 0, 0);
        add_row(md_op(rv_isa_pkg::F3_MULH, 26, 6, 4), 26, 32'hffffffff, 0, 0);
        add_row(md_op(rv_isa_pkg::F3_MULHSU, 27, 6, 2), 27, 32'hfffffff9, 0, 0);
        add_row(md_op(rv_isa_pkg::F3_MULHU, 28, 6, 2), 28, 32'hfffffff8, 0, 0);
        add_row(md_op(rv_isa_pkg::F3_MULH, 29, 1, 1), 29, 32'h40000000, 0, 0);
        add_row(md_op(rv_isa_pkg::F3_MULH, 30, 6, 2), 30, 32'h00000000, 0, 0);
        // divide and remainder
        add_row(md_op(rv_isa_pkg::F3_DIV, 25, 4, 6), 25, 32'hfd663ccb, 0, 0);
        add_row(md_op(rv_isa_pkg::F3_REM, 26, 4, 6), 26, 32'h00000005, 0, 0);
        add_row(md_op(rv_isa_pkg::F3_DIVU, 27, 2, 3), 27, 32'h24924924, 0, 0);
        add_row(md_op(rv_isa_pkg::F3_REMU, 28, 2, 3), 28, 32'h00000003, 0, 0);
        add_row(md_op(rv_isa_pkg::F3_REM, 29, 6, 4), 29, 32'hfffffff9, 0, 0);
        add_row(md_op(rv_isa_pkg::F3_DIV, 30, 4, 0), 30, 32'hffffffff, 0, 0);
        add_row(md_op(rv_isa_pkg::F3_REM, 31, 6, 0), 31, 32'hfffffff9, 0, 0);
        add_row(md_op(rv_isa_pkg::F3_DIVU, 30, 4, 0), 30, 32'hffffffff, 0, 0);
        add_row(md_op(rv_isa_pkg::F3_REMU, 31, 4, 0), 31, 32'h12345678, 0, 0);
        add_row(md_op(rv_isa_pkg::F3_DIV, 30, 1, 2), 30, 32'h80000000, 0, 0);
        add_row(md_op(rv_isa_pkg::F3_REM, 31, 1, 2), 31, 32'h00000000, 0, 0);
        // x0 result is reported but not kept
        add_row(imm_op(rv_isa_pkg::F3_ADD_SUB, 0, 3, 12'h005), 0, 32'h0000000c, 0, 1);
        add_row(rr_op(rv_isa_pkg::F3_ADD_SUB, 0, 24, 0, 3), 24, 32'h00000007, 0, 1);
        // lw x3, 0(x1) and a sub-only funct7 on or
        add_row({12'h000, 5'd1, 3'b010, 5'd3, 7'b0000011}, 3, 32'h0, 1, 1);
        add_row(rr_op(rv_isa_pkg::F3_OR, 1, 5, 4, 3), 5, 32'h0, 1, 1);
        add_row(rr_op(rv_isa_pkg::F3_ADD_SUB, 0, 24, 3, 5), 24, 32'hedcba98e, 0, 1);
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input exec_pkg::word_t got,
                              input exec_pkg::word_t exp);
        if (got !== exp)
            report_failure($sformatf("mismatch %s got 0x%08h exp 0x%08h", name, got, exp));
    endtask

    task automatic check_reg(input string name, input exec_pkg::reg_idx_t got,
                             input exec_pkg::reg_idx_t exp);
        if (got !== exp)
            report_failure($sformatf("mismatch %s got 0x%02h exp 0x%02h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input bit got, input bit exp);
        if (got !== exp)
            report_failure($sformatf("mismatch %s got 0x%0h exp 0x%0h", name, got, exp));
    endtask

    task automatic compare_regs();
        for (int i = 0; i < 32; i++)
            check_word($sformatf("x%0d", i), dut_i.regs_i.regs[i], ref_regs[i]);
    endtask

    task automatic run_row(input row_t r);
        int lat;
        instr_valid = 1'b1;
        instr       = r.instr;
        while (!instr_ready)
            @(negedge clk);
        @(posedge clk);  // accepted here
        @(negedge clk);
        instr_valid = 1'b0;
        instr       = '0;
        lat = 0;
        while (!retire_valid) begin
            @(negedge clk);
            lat++;
        end
        if (r.lat3 && lat != 3)
            report_failure($sformatf("retired %0d cycles after acceptance instead of 3", lat));
        check_reg("retire_rd", retire_rd, r.rd);
        check_word("retire_value", retire_value, r.value);
        check_flag("retire_illegal", retire_illegal, r.ill);
        if (!r.ill && r.rd != '0)
            ref_regs[r.rd] = r.value;
        compare_regs();
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        foreach (ref_regs[i])
            ref_regs[i] = '0;
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (rows[i])
            run_row(rows[i]);
        $display("No errors");
        $finish;
    end

    // protocol checker failures
    initial begin
        wait (dut_i.sva_i.fail_count != 0);
        report_failure("a protocol assertion on exec_core failed");
    end

    // watchdog sized from the table length
    initial begin
        int limit;
        #1;
        limit = rows.size() * 40 + 5;
        repeat (limit) @(posedge clk);
        report_failure($sformatf("run timed out after %0d cycles", limit));
    end

endmodule

// File: writeback_unit.sv
module writeback_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  exec_pkg::reg_idx_t rd,
    input  logic               illegal,
    input  logic               illegal_valid,
    input  logic               alu_done,
    input  exec_pkg::word_t    alu_result,
    input  logic               muldiv_done,
    input  exec_pkg::word_t    muldiv_result,
    output logic               wr_en,
    output exec_pkg::reg_idx_t wr_addr,
    output exec_pkg::word_t    wr_data,
    output logic               retire_valid,
    output exec_pkg::reg_idx_t retire_rd,
    output exec_pkg::word_t    retire_value,
    output logic               retire_illegal
);

    logic ill_q;  // stands in for the alu stage

    assign wr_en   = (alu_done || muldiv_done) && !illegal;
    assign wr_addr = rd;
    assign wr_data = muldiv_done ? muldiv_result : alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ill_q        <= 1'b0;
            retire_valid <= 1'b0;
        end else begin
            ill_q        <= illegal_valid;
            retire_valid <= alu_done || muldiv_done || ill_q;
        end
    end

    always_ff @(posedge clk) begin
        retire_rd      <= rd;
        retire_value   <= ill_q ? '0 : wr_data;
        retire_illegal <= ill_q;
    end

endmodule
